//--- verilog/conv_pkg.sv
package conv_pkg;

    // window side and tap count
    localparam int KERNEL = 3;
    localparam int TAPS   = KERNEL * KERNEL;

    // signed ifmap pixel
    typedef logic signed [7:0] pixel_t;

    // signed kernel weight
    typedef logic signed [7:0] weight_t;

    // one pixel times one weight
    typedef logic signed [15:0] product_t;

    // full 9-tap sum, 9*128*128 fits with room to spare
    typedef logic signed [19:0] acc_t;

    // one window row, leftmost pixel in the top element
    typedef pixel_t [KERNEL-1:0] win_row_t;

endpackage

//--- verilog/window_if.sv
`timescale 1ns/1ps

// carries one 3x3 window per valid/ready transfer
interface window_if import conv_pkg::*; ();

    logic     valid;
    logic     ready;
    win_row_t row_top;
    win_row_t row_mid;
    win_row_t row_bot;

    modport producer (
        output valid,
        output row_top,
        output row_mid,
        output row_bot,
        input  ready
    );

    modport consumer (
        input  valid,
        input  row_top,
        input  row_mid,
        input  row_bot,
        output ready
    );

endinterface

//--- verilog/line_window.sv
`timescale 1ns/1ps

module line_window import conv_pkg::*; #(
    parameter int IMG_W = 8,
    parameter int IMG_H = 6
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       pix_req,
    input  pixel_t     pix_data,
    output logic       pix_ack,
    window_if.producer win
);

    localparam int CW = (IMG_W > 1) ? $clog2(IMG_W) : 1;
    localparam int RW = (IMG_H > 1) ? $clog2(IMG_H) : 1;

    typedef enum logic {
        S_IDLE,
        S_ACK
    } state_t;

    state_t        state;
    logic [CW-1:0] col;
    logic [RW-1:0] row;
    logic          last_col;
    logic          last_row;
    logic          win_hit;
    logic          take;
    logic          accept;

    // rows r-2 and r-1, one pixel per column
    pixel_t lb_top [IMG_W];
    pixel_t lb_mid [IMG_W];

    // the two previous columns of each window row
    pixel_t [KERNEL-2:0] hist_top;
    pixel_t [KERNEL-2:0] hist_mid;
    pixel_t [KERNEL-2:0] hist_bot;

    assign last_col = (col == CW'(IMG_W - 1));
    assign last_row = (row == RW'(IMG_H - 1));

    // new pixel is the bottom-right corner of a full window
    assign win_hit = (row >= RW'(KERNEL - 1)) && (col >= CW'(KERNEL - 1));

    assign take = (state == S_IDLE) && pix_req;

    // pixel and its window go in on the same edge
    assign accept = take && (!win_hit || win.ready);

    assign pix_ack = (state == S_ACK);

    // window held steady by pix_data, which is stable while pix_req is high
    assign win.valid   = take && win_hit;
    assign win.row_top = {hist_top, lb_top[col]};
    assign win.row_mid = {hist_mid, lb_mid[col]};
    assign win.row_bot = {hist_bot, pix_data};

    // four-phase ack and raster counters
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= S_IDLE;
            col   <= '0;
            row   <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (accept) begin
                        state <= S_ACK;
                        if (last_col) begin
                            col <= '0;
                            // wrap to a fresh frame after the last row
                            if (last_row) begin
                                row <= '0;
                            end else begin
                                row <= row + RW'(1);
                            end
                        end else begin
                            col <= col + CW'(1);
                        end
                    end
                end
                S_ACK: begin
                    if (!pix_req) begin
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // line buffers move down one row at this column
    always_ff @(posedge clk) begin
        if (accept) begin
            lb_top[col] <= lb_mid[col];
            lb_mid[col] <= pix_data;
            hist_top    <= win.row_top[KERNEL-2:0];
            hist_mid    <= win.row_mid[KERNEL-2:0];
            hist_bot    <= win.row_bot[KERNEL-2:0];
        end
    end

endmodule

//--- verilog/window_fifo.sv
`timescale 1ns/1ps

module window_fifo import conv_pkg::*; #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic       clk,
    input  logic       rst,
    window_if.consumer wr,
    window_if.producer rd
);

    localparam int AW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

    win_row_t mem_top [FIFO_DEPTH];
    win_row_t mem_mid [FIFO_DEPTH];
    win_row_t mem_bot [FIFO_DEPTH];

    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          push;
    logic          pop;

    function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] ptr);
        return (ptr == AW'(FIFO_DEPTH - 1)) ? '0 : ptr + AW'(1);
    endfunction

    assign wr.ready = (count != (AW + 1)'(FIFO_DEPTH));
    assign rd.valid = (count != '0);

    assign push = wr.valid && wr.ready;
    assign pop  = rd.valid && rd.ready;

    // head entry, visible the cycle after it was written
    assign rd.row_top = mem_top[rd_ptr];
    assign rd.row_mid = mem_mid[rd_ptr];
    assign rd.row_bot = mem_bot[rd_ptr];

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            if (push && !pop) begin
                count <= count + (AW + 1)'(1);
            end else if (pop && !push) begin
                count <= count - (AW + 1)'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem_top[wr_ptr] <= wr.row_top;
            mem_mid[wr_ptr] <= wr.row_mid;
            mem_bot[wr_ptr] <= wr.row_bot;
        end
    end

endmodule

//--- verilog/mac_array.sv
`timescale 1ns/1ps

module mac_array import conv_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       weight_we,
    input  logic [3:0] weight_idx,
    input  weight_t    weight_data,
    window_if.consumer win,
    output logic       res_req,
    input  logic       res_ack,
    output acc_t       res_data
);

    // kernel in row-major order, index 0 is top-left
    weight_t  w [TAPS];
    pixel_t   taps [TAPS];
    product_t s1_prod [TAPS];
    acc_t     s2_sum [KERNEL];

    logic s1_valid;
    logic s2_valid;
    logic out_free;
    logic s2_free;
    logic s1_free;
    logic s1_load;
    logic s2_load;
    logic out_load;

    // output register free only once the last result is fully retired
    assign out_free = !res_req && !res_ack;
    assign s2_free  = !s2_valid || out_free;
    assign s1_free  = !s1_valid || s2_free;

    assign win.ready = s1_free;

    assign s1_load  = win.valid && s1_free;
    assign s2_load  = s1_valid && s2_free;
    assign out_load = s2_valid && out_free;

    // unpack window rows, leftmost pixel sits in the top element
    always_comb begin
        for (int j = 0; j < KERNEL; j++) begin
            taps[j]            = win.row_top[KERNEL-1-j];
            taps[KERNEL+j]     = win.row_mid[KERNEL-1-j];
            taps[2*KERNEL+j]   = win.row_bot[KERNEL-1-j];
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int k = 0; k < TAPS; k++) begin
                w[k] <= '0;
            end
        end else if (weight_we && (weight_idx < 4'(TAPS))) begin
            w[weight_idx] <= weight_data;
        end
    end

    // stage valids and result handshake
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            res_req  <= 1'b0;
        end else begin
            if (s1_free) begin
                s1_valid <= win.valid;
            end
            if (s2_free) begin
                s2_valid <= s1_valid;
            end
            if (out_load) begin
                res_req <= 1'b1;
            end else if (res_req && res_ack) begin
                res_req <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        // multiply
        if (s1_load) begin
            for (int k = 0; k < TAPS; k++) begin
                s1_prod[k] <= product_t'(taps[k]) * product_t'(w[k]);
            end
        end
        // row sums
        if (s2_load) begin
            for (int i = 0; i < KERNEL; i++) begin
                s2_sum[i] <= acc_t'(s1_prod[KERNEL*i])
                           + acc_t'(s1_prod[KERNEL*i+1])
                           + acc_t'(s1_prod[KERNEL*i+2]);
            end
        end
        // held until res_ack falls
        if (out_load) begin
            res_data <= s2_sum[0] + s2_sum[1] + s2_sum[2];
        end
    end

endmodule

//--- verilog/conv_top.sv
`timescale 1ns/1ps

module conv_top import conv_pkg::*; #(
    parameter int IMG_W      = 8,
    parameter int IMG_H      = 6,
    parameter int FIFO_DEPTH = 4
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       pix_req,
    input  pixel_t     pix_data,
    output logic       pix_ack,
    input  logic       weight_we,
    input  logic [3:0] weight_idx,
    input  weight_t    weight_data,
    output logic       res_req,
    input  logic       res_ack,
    output acc_t       res_data
);

    // window former to FIFO, FIFO to MAC array
    window_if lw_if ();
    window_if mac_if ();

    line_window #(
        .IMG_W (IMG_W),
        .IMG_H (IMG_H)
    ) u_line_window (
        .clk      (clk),
        .rst      (rst),
        .pix_req  (pix_req),
        .pix_data (pix_data),
        .pix_ack  (pix_ack),
        .win      (lw_if.producer)
    );

    window_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_window_fifo (
        .clk (clk),
        .rst (rst),
        .wr  (lw_if.consumer),
        .rd  (mac_if.producer)
    );

    mac_array u_mac_array (
        .clk         (clk),
        .rst         (rst),
        .weight_we   (weight_we),
        .weight_idx  (weight_idx),
        .weight_data (weight_data),
        .win         (mac_if.consumer),
        .res_req     (res_req),
        .res_ack     (res_ack),
        .res_data    (res_data)
    );

endmodule

//--- tests/tb_clock.sv
`timescale 1ns/1ps

// free-running clock, 10 ns period
module tb_clock (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

endmodule

//--- tests/conv_assert.sv
`timescale 1ns/1ps

module conv_assert import conv_pkg::*; (
    input logic clk,
    input logic rst,
    input logic pix_req,
    input logic pix_ack,
    input logic res_req,
    input logic res_ack,
    input acc_t res_data
);

    // ack only ever answers a request
    ack_needs_req: assert property (@(posedge clk) disable iff (!rst)
        $rose(pix_ack) |-> $past(pix_req))
        else $error("pix_ack rose while pix_req was low");

    // result held for the whole request phase
    data_held: assert property (@(posedge clk) disable iff (!rst)
        (res_req && $past(res_req)) |-> $stable(res_data))
        else $error("res_data changed while res_req was high");

    // request withdrawn only after the sink acknowledged
    req_until_ack: assert property (@(posedge clk) disable iff (!rst)
        $fell(res_req) |-> $past(res_ack))
        else $error("res_req fell before res_ack was high");

endmodule

bind conv_top conv_assert u_conv_assert (.*);

//--- tests/conv_tb.sv
`timescale 1ns/1ps

module conv_tb import conv_pkg::*; ();

    localparam int IMG_W      = 8;
    localparam int IMG_H      = 6;
    localparam int FIFO_DEPTH = 4;
    localparam int NPIX       = IMG_W * IMG_H;
    // seven frames over all tests at 60 cycles per pixel
    localparam int WATCHDOG_CYCLES = 7 * NPIX * 60 + 2000;
    localparam int RESULT_WAIT     = 500;

    logic       clk;
    logic       rst;
    logic       pix_req;
    pixel_t     pix_data;
    logic       pix_ack;
    logic       weight_we;
    logic [3:0] weight_idx;
    weight_t    weight_data;
    logic       res_req;
    logic       res_ack;
    acc_t       res_data;

    pixel_t      frame [NPIX];
    weight_t     w_model [TAPS];
    int          exp_q [$];
    logic [15:0] lfsr;
    int          errors;
    int          n_pass;
    int          n_fail;

    tb_clock u_clock (.clk(clk));

    conv_top #(
        .IMG_W      (IMG_W),
        .IMG_H      (IMG_H),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) DUT (.*);

    // taps x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [7:0] take_bits(input int n);
        logic [7:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            v = {v[6:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic void model_results();
        int s;
        exp_q.delete();
        for (int r = 2; r < IMG_H; r++) begin
            for (int c = 2; c < IMG_W; c++) begin
                s = 0;
                for (int i = 0; i < KERNEL; i++) begin
                    for (int j = 0; j < KERNEL; j++) begin
                        s += int'(frame[(r - 2 + i) * IMG_W + c - 2 + j])
                           * int'(w_model[KERNEL * i + j]);
                    end
                end
                exp_q.push_back(s);
            end
        end
    endfunction

    function automatic void random_frame();
        for (int k = 0; k < NPIX; k++) begin
            frame[k] = pixel_t'(take_bits(8));
        end
    endfunction

    function automatic void random_weights();
        for (int k = 0; k < TAPS; k++) begin
            w_model[k] = weight_t'(take_bits(8));
        end
    endfunction

    task automatic load_weights();
        for (int k = 0; k < TAPS; k++) begin
            @(posedge clk);
            weight_we   <= 1'b1;
            weight_idx  <= 4'(k);
            weight_data <= w_model[k];
        end
        @(posedge clk);
        weight_we <= 1'b0;
    endtask

    task automatic send_pixel(input pixel_t p);
        @(posedge clk);
        pix_data <= p;
        pix_req  <= 1'b1;
        do @(posedge clk); while (!pix_ack);
        pix_req <= 1'b0;
        do @(posedge clk); while (pix_ack);
    endtask

    task automatic send_frame();
        for (int k = 0; k < NPIX; k++) begin
            send_pixel(frame[k]);
        end
    endtask

    task automatic collect_results(input bit slow_sink);
        acc_t got;
        int   delay;
        int   waited;
        for (int k = 0; k < exp_q.size(); k++) begin
            waited = 0;
            do begin
                @(posedge clk);
                waited++;
            end while (!res_req && waited < RESULT_WAIT);
            if (!res_req) begin
                $display("result %0d of %0d never arrived", k, exp_q.size());
                errors++;
                break;
            end
            delay = slow_sink ? int'(take_bits(4)) : 0;
            repeat (delay) @(posedge clk);
            got = res_data;
            res_ack <= 1'b1;
            do @(posedge clk); while (res_req);
            res_ack <= 1'b0;
            if (got !== acc_t'(exp_q[k])) begin
                $display("FAIL %0t result %0d expected %0d got %0d", $time, k, exp_q[k], got);
                errors++;
            end
        end
    endtask

    task automatic run_frame(input bit slow_sink);
        bit extra;
        fork
            send_frame();
            collect_results(slow_sink);
        join
        extra = 1'b0;
        repeat (20) begin
            @(posedge clk);
            if (res_req) begin
                extra = 1'b1;
            end
        end
        if (extra) begin
            $display("an extra result came after the expected %0d", exp_q.size());
            errors++;
        end
    endtask

    task automatic end_test(input string name, input int start);
        if (errors == start) begin
            n_pass++;
            $display("%s: ok", name);
        end else begin
            n_fail++;
            $display("%s: %0d errors", name, errors - start);
        end
    endtask

    task automatic test_reset();
        int start;
        bit early;
        start = errors;
        early = 1'b0;
        @(posedge clk);
        if (pix_ack !== 1'b0 || res_req !== 1'b0) begin
            $display("FAIL %0t after reset expected pix_ack 0 res_req 0 got %b %b",
                     $time, pix_ack, res_req);
            errors++;
        end
        repeat (20) begin
            @(posedge clk);
            if (res_req !== 1'b0) begin
                early = 1'b1;
            end
        end
        if (early) begin
            $display("a result appeared before any pixel was sent");
            errors++;
        end
        end_test("reset", start);
    endtask

    task automatic test_identity();
        int start;
        start = errors;
        for (int k = 0; k < TAPS; k++) begin
            w_model[k] = (k == TAPS / 2) ? weight_t'(1) : weight_t'(0);
        end
        load_weights();
        random_frame();
        exp_q.delete();
        // identity kernel passes the window centre through
        for (int r = 1; r < IMG_H - 1; r++) begin
            for (int c = 1; c < IMG_W - 1; c++) begin
                exp_q.push_back(int'(frame[r * IMG_W + c]));
            end
        end
        run_frame(1'b0);
        end_test("identity kernel", start);
    endtask

    task automatic test_random(input string name, input bit slow_sink, input int frames);
        int start;
        start = errors;
        // weights reloaded between frames
        repeat (frames) begin
            random_weights();
            load_weights();
            random_frame();
            model_results();
            run_frame(slow_sink);
        end
        end_test(name, start);
    endtask

    task automatic extreme_frame(input weight_t wv, input int expect_val);
        for (int k = 0; k < TAPS; k++) begin
            w_model[k] = wv;
        end
        load_weights();
        exp_q.delete();
        repeat ((IMG_H - 2) * (IMG_W - 2)) exp_q.push_back(expect_val);
        run_frame(1'b0);
    endtask

    task automatic test_extremes();
        int start;
        start = errors;
        for (int k = 0; k < NPIX; k++) begin
            frame[k] = pixel_t'(-128);
        end
        extreme_frame(weight_t'(-128), 147456);
        extreme_frame(weight_t'(127), -146304);
        end_test("extremes", start);
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display("tests failed");
        $finish;
    end

    initial begin
        rst         = 1'b0;
        pix_req     = 1'b0;
        pix_data    = '0;
        weight_we   = 1'b0;
        weight_idx  = '0;
        weight_data = '0;
        res_ack     = 1'b0;
        lfsr        = 16'd40;
        errors      = 0;
        n_pass      = 0;
        n_fail      = 0;
        repeat (2) @(posedge clk);
        rst <= 1'b1;
        test_reset();
        test_identity();
        test_random("random weights", 1'b0, 1);
        test_random("back-pressure", 1'b1, 1);
        test_random("two frames", 1'b0, 2);
        test_extremes();
        $display("%0d passed, %0d failed", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- tb.f
verilog/conv_pkg.sv
verilog/window_if.sv
verilog/line_window.sv
verilog/window_fifo.sv
verilog/mac_array.sv
verilog/conv_top.sv
tests/tb_clock.sv
tests/conv_assert.sv
tests/conv_tb.sv

//--- run.sh
#!/bin/sh
# build and run the convolution testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module conv_tb -Mdir obj_dir -f tb.f
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

out=$(./obj_dir/Vconv_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "all tests passed"; then
    exit 0
fi
echo "pass message not found"
exit 1
